// File: design/cgmii_pkg.sv
`default_nettype none

package cgmii_pkg;

	localparam int FIFO_DEPTH    = 8;                      // Buffer entries and initial credits
	localparam int FIFO_PTR_NBIT = $clog2(FIFO_DEPTH);     // Read and write pointer width
	localparam int CREDIT_NBIT   = 4;                      // Holds 0 up to FIFO_DEPTH
	localparam int IDLE_NBIT     = 5;
	localparam int DATA_NBIT     = 8;
	localparam int COUNT_NBIT    = 16;                     // Frame and error counters

	// Control characters sent with ctrl high
	localparam logic [7:0] CHAR_IDLE  = 8'h07;
	localparam logic [7:0] CHAR_TERM  = 8'hFD;
	localparam logic [7:0] CHAR_ERROR = 8'hFE;

	// Frame machine states
	typedef enum logic [2:0] {
		ST_INIT = 3'd0,                                    // Latch frame lengths
		ST_TX_C = 3'd1,                                    // Control idles
		ST_TX_D = 3'd2,                                    // Data bytes
		ST_TX_T = 3'd3,                                    // Terminate
		ST_TX_E = 3'd4                                     // Error character
	} tx_state_t;

	// Debug opcodes that force the next state
	typedef enum logic [2:0] {
		DBG_NONE        = 3'd0,
		DBG_FORCE_ERROR = 3'd1,
		DBG_FORCE_IDLE  = 3'd2,
		DBG_FORCE_DATA  = 3'd3,
		DBG_FORCE_TERM  = 3'd4
	} debug_op_t;

endpackage

`default_nettype wire

// File: design/char_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// One character per cycle downstream, one credit per freed entry upstream
interface char_link_if;

	logic       valid;       // Character present this cycle
	logic [7:0] data;        // Byte value
	logic       ctrl;        // High for control characters
	logic       credit;      // One-cycle pulse per freed entry

	modport source (
		output valid,
		output data,
		output ctrl,
		input  credit
	);

	modport sink (
		input  valid,
		input  data,
		input  ctrl,
		output credit
	);

endinterface

`default_nettype wire

// File: design/cgmii_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cgmii_frame_fsm (
	input  wire logic                             i_clock,
	input  wire logic                             i_reset,
	input  wire logic [cgmii_pkg::IDLE_NBIT-1:0]  i_nidle,
	input  wire logic [cgmii_pkg::DATA_NBIT-1:0]  i_ndata,
	input  wire cgmii_pkg::debug_op_t             i_debug,
	char_link_if.source                           link
);

	cgmii_pkg::tx_state_t              state;
	cgmii_pkg::tx_state_t              state_next;
	logic [cgmii_pkg::IDLE_NBIT-1:0]   idle_cnt;
	logic [cgmii_pkg::IDLE_NBIT-1:0]   idle_cnt_next;
	logic [cgmii_pkg::DATA_NBIT-1:0]   data_cnt;
	logic [cgmii_pkg::DATA_NBIT-1:0]   data_cnt_next;
	logic [cgmii_pkg::IDLE_NBIT-1:0]   n_idle;         // Latched idle length of at least one
	logic [cgmii_pkg::DATA_NBIT-1:0]   n_data;         // Latched data length of at least one
	logic [cgmii_pkg::CREDIT_NBIT-1:0] credits;
	logic                              can_send;
	logic                              emit;
	logic [7:0]                        char_data;
	logic                              char_ctrl;

	assign can_send = (credits != '0);

	always_comb begin
		state_next    = state;
		idle_cnt_next = idle_cnt;
		data_cnt_next = data_cnt;
		emit          = 1'b0;
		char_data     = cgmii_pkg::CHAR_IDLE;
		char_ctrl     = 1'b1;

		case (state)
			cgmii_pkg::ST_INIT: begin
				state_next = cgmii_pkg::ST_TX_C;        // Nothing sent here
			end
			cgmii_pkg::ST_TX_C: begin
				emit = can_send;
				if (can_send) begin
					if (idle_cnt == n_idle - 1'b1) begin
						idle_cnt_next = '0;
						state_next    = cgmii_pkg::ST_TX_D;
					end else begin
						idle_cnt_next = idle_cnt + 1'b1;
					end
				end
			end
			cgmii_pkg::ST_TX_D: begin
				emit      = can_send;
				char_data = data_cnt;                   // Bytes count up from zero
				char_ctrl = 1'b0;
				if (can_send) begin
					if (data_cnt == n_data - 1'b1) begin
						data_cnt_next = '0;
						state_next    = cgmii_pkg::ST_TX_T;
					end else begin
						data_cnt_next = data_cnt + 1'b1;
					end
				end
			end
			cgmii_pkg::ST_TX_T: begin
				emit      = can_send;
				char_data = cgmii_pkg::CHAR_TERM;
				if (can_send)
					state_next = cgmii_pkg::ST_INIT;
			end
			cgmii_pkg::ST_TX_E: begin
				emit      = can_send;
				char_data = cgmii_pkg::CHAR_ERROR;
				if (can_send) begin
					idle_cnt_next = '0;
					data_cnt_next = '0;
					state_next    = cgmii_pkg::ST_TX_C;
				end
			end
			default: begin
				state_next = cgmii_pkg::ST_INIT;        // Recover from unused codes
			end
		endcase

		// Debug forcing wins over the normal next state
		case (i_debug)
			cgmii_pkg::DBG_FORCE_ERROR: begin
				state_next    = cgmii_pkg::ST_TX_E;
				idle_cnt_next = '0;
				data_cnt_next = '0;
			end
			cgmii_pkg::DBG_FORCE_IDLE: begin
				state_next    = cgmii_pkg::ST_TX_C;
				idle_cnt_next = '0;
			end
			cgmii_pkg::DBG_FORCE_DATA: begin
				state_next    = cgmii_pkg::ST_TX_D;
				data_cnt_next = '0;
			end
			cgmii_pkg::DBG_FORCE_TERM: state_next = cgmii_pkg::ST_TX_T;
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state    <= cgmii_pkg::ST_INIT;
			idle_cnt <= '0;
			data_cnt <= '0;
			credits  <= cgmii_pkg::CREDIT_NBIT'(cgmii_pkg::FIFO_DEPTH);
		end else begin
			state    <= state_next;
			idle_cnt <= idle_cnt_next;
			data_cnt <= data_cnt_next;
			if (emit && !link.credit)
				credits <= credits - 1'b1;              // Entry consumed downstream
			else if (!emit && link.credit)
				credits <= credits + 1'b1;              // Entry freed downstream
		end
	end

	// Lengths sampled once per frame with zero taken as one
	always_ff @(posedge i_clock) begin
		if (state == cgmii_pkg::ST_INIT) begin
			n_idle <= (i_nidle == '0) ? cgmii_pkg::IDLE_NBIT'(1) : i_nidle;
			n_data <= (i_ndata == '0) ? cgmii_pkg::DATA_NBIT'(1) : i_ndata;
		end
	end

	assign link.valid = emit;
	assign link.data  = char_data;
	assign link.ctrl  = char_ctrl;

endmodule

`default_nettype wire

// File: design/char_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module char_fifo (
	input  wire logic i_clock,
	input  wire logic i_reset,
	char_link_if.sink   in_link,
	char_link_if.source out_link
);

	logic [8:0]                          mem [cgmii_pkg::FIFO_DEPTH];   // {ctrl, byte}
	logic [cgmii_pkg::FIFO_PTR_NBIT-1:0] wr_ptr;
	logic [cgmii_pkg::FIFO_PTR_NBIT-1:0] rd_ptr;
	logic [cgmii_pkg::CREDIT_NBIT-1:0]   count;
	logic                                push;
	logic                                pop;
	logic [8:0]                          head;

	assign push = in_link.valid;                  // Credits guarantee a free slot
	assign pop  = out_link.credit && (count != '0);

	always_ff @(posedge i_clock) begin
		if (push)
			mem[wr_ptr] <= {in_link.ctrl, in_link.data};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;                 // Wraps at FIFO_DEPTH
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (!push && pop)
				count <= count - 1'b1;
		end
	end

	assign head = mem[rd_ptr];

	assign out_link.valid = (count != '0);
	assign out_link.data  = head[7:0];
	assign out_link.ctrl  = head[8];

	// Every entry removed returns one credit to the producer
	assign in_link.credit = pop;

endmodule

`default_nettype wire

// File: design/cgmii_tx_output.sv
`timescale 1ns/1ps
`default_nettype none

module cgmii_tx_output (
	input  wire logic                         i_clock,
	input  wire logic                         i_reset,
	char_link_if.sink                         link,
	input  wire logic                         i_ready,
	output logic [7:0]                        o_txd,
	output logic                              o_txc,
	output logic                              o_valid,
	output logic [cgmii_pkg::COUNT_NBIT-1:0]  o_frame_count,
	output logic [cgmii_pkg::COUNT_NBIT-1:0]  o_error_count
);

	logic take;
	logic is_term;
	logic is_error;

	assign take     = link.valid && i_ready;
	assign is_term  = link.ctrl && (link.data == cgmii_pkg::CHAR_TERM);
	assign is_error = link.ctrl && (link.data == cgmii_pkg::CHAR_ERROR);

	assign link.credit = take;                        // Pops the head this cycle

	always_ff @(posedge i_clock) begin
		if (take) begin
			o_txd <= link.data;
			o_txc <= link.ctrl;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid       <= 1'b0;
			o_frame_count <= '0;
			o_error_count <= '0;
		end else begin
			o_valid <= take;                             // Low the cycle after i_ready drops
			if (take && is_term)
				o_frame_count <= o_frame_count + 1'b1;
			if (take && is_error)
				o_error_count <= o_error_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/cgmii_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module cgmii_tx_top (
	input  wire logic                             i_clock,
	input  wire logic                             i_reset,
	input  wire logic [cgmii_pkg::IDLE_NBIT-1:0]  i_nidle,
	input  wire logic [cgmii_pkg::DATA_NBIT-1:0]  i_ndata,
	input  wire cgmii_pkg::debug_op_t             i_debug,
	input  wire logic                             i_ready,
	output logic [7:0]                            o_txd,
	output logic                                  o_txc,
	output logic                                  o_valid,
	output logic [cgmii_pkg::COUNT_NBIT-1:0]      o_frame_count,
	output logic [cgmii_pkg::COUNT_NBIT-1:0]      o_error_count
);

	char_link_if prod_link ();                    // Frame machine to FIFO
	char_link_if cons_link ();                    // FIFO to output stage

	cgmii_frame_fsm u_frame_fsm (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_nidle (i_nidle),
		.i_ndata (i_ndata),
		.i_debug (i_debug),
		.link    (prod_link.source)
	);

	char_fifo u_char_fifo (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.in_link  (prod_link.sink),
		.out_link (cons_link.source)
	);

	cgmii_tx_output u_tx_output (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.link          (cons_link.sink),
		.i_ready       (i_ready),
		.o_txd         (o_txd),
		.o_txc         (o_txc),
		.o_valid       (o_valid),
		.o_frame_count (o_frame_count),
		.o_error_count (o_error_count)
	);

endmodule

`default_nettype wire

// File: test/cgmii_tx_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cgmii_tx_chk (
	input wire logic                              i_clock,
	input wire logic                              i_reset,
	input wire logic                              i_ready,
	input wire logic                              i_out_valid,
	input wire logic                              i_prod_valid,
	input wire logic [cgmii_pkg::CREDIT_NBIT-1:0] i_credits,
	input wire logic [cgmii_pkg::CREDIT_NBIT-1:0] i_fifo_count
);

	// Producer may only send into a free FIFO slot
	no_send_into_full: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_fifo_count == cgmii_pkg::CREDIT_NBIT'(cgmii_pkg::FIFO_DEPTH)) |-> !i_prod_valid)
		else $error("Producer sent a character into a full FIFO");

	// Credits held plus entries stored add up to the depth
	credits_match_fifo: assert property (@(posedge i_clock) disable iff (i_reset)
		(int'(i_credits) + int'(i_fifo_count)) == cgmii_pkg::FIFO_DEPTH)
		else $error("Producer credits and FIFO occupancy disagree");

	fifo_count_bounded: assert property (@(posedge i_clock) disable iff (i_reset)
		i_fifo_count <= cgmii_pkg::CREDIT_NBIT'(cgmii_pkg::FIFO_DEPTH))
		else $error("FIFO holds more entries than its depth");

	valid_low_after_stall: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_ready |=> !i_out_valid)
		else $error("Output valid was high the cycle after ready was low");

endmodule

bind cgmii_tx_top cgmii_tx_chk u_tx_chk (
	.i_clock      (i_clock),
	.i_reset      (i_reset),
	.i_ready      (i_ready),
	.i_out_valid  (o_valid),
	.i_prod_valid (prod_link.valid),
	.i_credits    (u_frame_fsm.credits),
	.i_fifo_count (u_char_fifo.count)
);

`default_nettype wire

// File: test/cgmii_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cgmii_tx_tb;

	localparam int N_ROWS       = 7;
	localparam int READY_ALWAYS = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_STALL  = 2;

	typedef struct packed {
		int nidle;
		int ndata;
		int nframes;                                    // Frames to see after any error
		int ready_mode;
		int err_after;                                  // Outputs before forcing an error or 0 for none
	} row_t;

	row_t rows [N_ROWS] = '{
		'{3, 5, 3, READY_ALWAYS, 0},
		'{0, 0, 4, READY_ALWAYS, 0},
		'{1, 20, 2, READY_ALWAYS, 0},
		'{2, 6, 4, READY_RANDOM, 0},
		'{2, 12, 3, READY_STALL, 0},
		'{2, 4, 2, READY_ALWAYS, 3},
		'{3, 3, 2, READY_RANDOM, 5}
	};
	string row_names [N_ROWS] = '{"basic", "zero_lengths", "long_data", "random_ready",
		"long_stall", "force_error", "error_random"};

	logic                 clock = 1'b0;
	logic                 reset;
	logic [4:0]           nidle;
	logic [7:0]           ndata;
	cgmii_pkg::debug_op_t debug;
	logic                 ready;
	logic [7:0]           txd;
	logic                 txc;
	logic                 out_valid;
	logic [15:0]          frame_count;
	logic [15:0]          error_count;
	logic [31:0]          rand_state = 32'd5;
	int                   cycle_count = 0;
	int                   cycle_limit = 0;

	cgmii_tx_top i_dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_nidle       (nidle),
		.i_ndata       (ndata),
		.i_debug       (debug),
		.i_ready       (ready),
		.o_txd         (txd),
		.o_txc         (txc),
		.o_valid       (out_valid),
		.o_frame_count (frame_count),
		.o_error_count (error_count)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycle_count);
			$display("Errors found");
			$fatal(1, "Timeout");
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int at_least_one(input int n);
		return (n == 0) ? 1 : n;
	endfunction

	// {ctrl, byte} at a position of the repeating frame
	function automatic logic [8:0] expected_char(input int ni, input int nd, input int pos);
		int p;
		p = pos % (ni + nd + 1);
		if (p < ni)
			return 9'h107;                              // Control idle
		else if (p < ni + nd)
			return {1'b0, 8'(p - ni)};                  // Data counts up from zero
		else
			return 9'h1FD;                              // Terminate
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic reset_dut(input int r);
		reset = 1'b1;
		ready = 1'b0;
		debug = cgmii_pkg::DBG_NONE;
		nidle = 5'(rows[r].nidle);
		ndata = 8'(rows[r].ndata);
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
	endtask

	initial begin
		int ni, nd, len, pos, seen, terms, frames_left, cyc;
		logic prev_ready, err_sent, err_seen;
		logic [8:0] exp_char;
		reset = 1'b1;
		ready = 1'b0;
		debug = cgmii_pkg::DBG_NONE;
		nidle = '0;
		ndata = '0;
		for (int r = 0; r < N_ROWS; r++) begin
			len = at_least_one(rows[r].nidle) + at_least_one(rows[r].ndata) + 1;
			cycle_limit += 10 + 40 * len * (rows[r].nframes + ((rows[r].err_after != 0) ? 2 : 0));
		end
		for (int r = 0; r < N_ROWS; r++) begin
			reset_dut(r);
			ni = at_least_one(rows[r].nidle);
			nd = at_least_one(rows[r].ndata);
			pos = 0;
			seen = 0;
			terms = 0;
			cyc = 0;
			frames_left = rows[r].nframes;
			prev_ready = 1'b0;
			err_sent = 1'b0;
			err_seen = 1'b0;
			while (frames_left > 0) begin
				@(posedge clock);
				#1;
				cyc++;
				debug = cgmii_pkg::DBG_NONE;
				if (!prev_ready)
					check_value({row_names[r], " valid after ready low"}, 32'd0, 32'(out_valid));
				if (out_valid) begin
					if (err_sent && !err_seen && txc && txd == 8'hFE) begin
						err_seen = 1'b1;                // Frame restarts at its idles
						pos = 0;
					end else begin
						exp_char = expected_char(ni, nd, pos);
						check_value($sformatf("%s char %0d", row_names[r], seen), 32'(exp_char),
							32'({txc, txd}));
						pos++;
						if (exp_char == 9'h1FD) begin
							terms++;
							if (rows[r].err_after == 0 || err_seen)
								frames_left--;
						end
					end
					seen++;
				end
				if (frames_left == 0) begin
					ready = 1'b0;                       // Stop taking so the counters settle
				end else begin
					case (rows[r].ready_mode)
						READY_RANDOM: begin
							rand_state = lcg_next(rand_state);
							ready = (rand_state[17:16] != 2'b00);
						end
						READY_STALL: ready = !(cyc >= 6 && cyc < 26);   // Longer than the FIFO
						default: ready = 1'b1;
					endcase
					if (rows[r].err_after != 0 && !err_sent && seen >= rows[r].err_after) begin
						debug = cgmii_pkg::DBG_FORCE_ERROR; // Held for one cycle only
						err_sent = 1'b1;
					end
				end
				prev_ready = ready;
			end
			check_value({row_names[r], " frame count"}, 32'(terms), 32'(frame_count));
			check_value({row_names[r], " error count"}, 32'(err_sent), 32'(error_count));
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
design/cgmii_pkg.sv
design/char_link_if.sv
design/cgmii_frame_fsm.sv
design/char_fifo.sv
design/cgmii_tx_output.sv
design/cgmii_tx_top.sv
test/cgmii_tx_chk.sv
test/cgmii_tx_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module cgmii_tx_tb \
	--Mdir obj_dir \
	-f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcgmii_tx_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
echo "Simulation finished cleanly"
